// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    //////////////////////////////
    // Datapath types
    //////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;

    //////////////////////////////
    // Primary opcodes
    //////////////////////////////

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type function field
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    //////////////////////////////
    // ALU operations
    //////////////////////////////

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_NOR  = 4'd5;
    localparam alu_op_t ALU_SLT  = 4'd6;
    localparam alu_op_t ALU_SLTU = 4'd7;
    // Immediate moved to the upper half
    localparam alu_op_t ALU_LUI  = 4'd8;

    // EX operand sources
    localparam fwd_sel_t FWD_NONE = 2'd0;
    localparam fwd_sel_t FWD_MEM  = 2'd1;
    localparam fwd_sel_t FWD_WB   = 2'd2;

    // First fetch address
    localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               we,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::reg_addr_t rd_addr,
    input  cpu_pkg::word_t     rd_data,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data
);

    cpu_pkg::word_t regs [32];

    // Rising-edge write, $0 never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Write-through so WB and ID can share a cycle
    always_comb begin
        if (rs_addr == 5'd0) begin
            rs_data = '0;
        end else if (we && (rd_addr == rs_addr)) begin
            rs_data = rd_data;
        end else begin
            rs_data = regs[rs_addr];
        end
    end

    always_comb begin
        if (rt_addr == 5'd0) begin
            rt_data = '0;
        end else if (we && (rd_addr == rt_addr)) begin
            rt_data = rd_data;
        end else begin
            rt_data = regs[rt_addr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,
    input  logic           jump_taken,
    input  logic           branch_taken,
    input  cpu_pkg::word_t jump_target,
    input  cpu_pkg::word_t branch_target,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_data,
    output cpu_pkg::word_t if_pc_4,
    output cpu_pkg::word_t if_instr
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t pc_4;
    cpu_pkg::word_t pc_next;

    // Instruction memory answers in the same cycle
    assign imem_addr = pc;
    assign pc_4      = pc + 32'd4;

    // Branch from EX is older than the jump in ID, so it wins
    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else if (stall) begin
            pc_next = pc;
        end else if (jump_taken) begin
            pc_next = jump_target;
        end else begin
            pc_next = pc_4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= cpu_pkg::RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    //////////////////////////////
    // IF/ID register
    //////////////////////////////

    // All-zero word decodes as a nop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_instr <= '0;
            if_pc_4  <= '0;
        end else if (branch_taken || jump_taken) begin
            if_instr <= '0;
            if_pc_4  <= pc_4;
        end else if (!stall) begin
            if_instr <= imem_data;
            if_pc_4  <= pc_4;
        end
    end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               branch_taken,
    input  cpu_pkg::word_t     if_pc_4,
    input  cpu_pkg::word_t     if_instr,
    input  logic               wb_reg_w,
    input  cpu_pkg::reg_addr_t wb_rd_addr,
    input  cpu_pkg::word_t     wb_data,
    output logic               jump_taken,
    output cpu_pkg::word_t     jump_target,
    output cpu_pkg::reg_addr_t id_rs_addr,
    output cpu_pkg::reg_addr_t id_rt_addr,
    output cpu_pkg::reg_addr_t ex_rs_addr,
    output cpu_pkg::reg_addr_t ex_rt_addr,
    output cpu_pkg::reg_addr_t ex_rd_addr,
    output cpu_pkg::word_t     ex_op_a,
    output cpu_pkg::word_t     ex_op_b,
    output cpu_pkg::word_t     ex_imm,
    output cpu_pkg::word_t     ex_pc_4,
    output cpu_pkg::alu_op_t   ex_alu_op,
    output logic               ex_b_imm,
    output logic               ex_reg_w,
    output logic               ex_mem_r,
    output logic               ex_mem_w,
    output logic               ex_beq,
    output logic               ex_bne
);

    cpu_pkg::opcode_t   opcode;
    cpu_pkg::funct_t    funct;
    cpu_pkg::alu_op_t   alu_op;
    cpu_pkg::reg_addr_t dst_addr;
    cpu_pkg::word_t     imm_ext;
    cpu_pkg::word_t     rs_data;
    cpu_pkg::word_t     rt_data;
    logic               b_imm;
    logic               reg_w;
    logic               mem_r;
    logic               mem_w;
    logic               beq;
    logic               bne;
    logic               dst_rt;
    logic               zero_ext;
    logic               use_rs;
    logic               use_rt;

    assign opcode = if_instr[31:26];
    assign funct  = if_instr[5:0];

    // Absolute jump keeps the upper PC bits
    assign jump_taken  = (opcode == cpu_pkg::OP_J);
    assign jump_target = {if_pc_4[31:28], if_instr[25:0], 2'b00};

    //////////////////////////////
    // Decoder
    //////////////////////////////

    always_comb begin
        alu_op   = cpu_pkg::ALU_ADD;
        b_imm    = 1'b0;
        reg_w    = 1'b0;
        mem_r    = 1'b0;
        mem_w    = 1'b0;
        beq      = 1'b0;
        bne      = 1'b0;
        dst_rt   = 1'b1;
        zero_ext = 1'b0;
        use_rs   = 1'b0;
        use_rt   = 1'b0;
        case (opcode)
            cpu_pkg::OP_RTYPE: begin
                dst_rt = 1'b0;
                use_rs = 1'b1;
                use_rt = 1'b1;
                reg_w  = 1'b1;
                case (funct)
                    cpu_pkg::FN_ADD, cpu_pkg::FN_ADDU: alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::FN_SUB, cpu_pkg::FN_SUBU: alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::FN_AND:  alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::FN_OR:   alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::FN_XOR:  alu_op = cpu_pkg::ALU_XOR;
                    cpu_pkg::FN_NOR:  alu_op = cpu_pkg::ALU_NOR;
                    cpu_pkg::FN_SLT:  alu_op = cpu_pkg::ALU_SLT;
                    cpu_pkg::FN_SLTU: alu_op = cpu_pkg::ALU_SLTU;
                    // Unsupported funct, including the all-zero nop
                    default: begin
                        reg_w  = 1'b0;
                        use_rs = 1'b0;
                        use_rt = 1'b0;
                    end
                endcase
            end
            cpu_pkg::OP_ADDI, cpu_pkg::OP_ADDIU: begin
                {b_imm, reg_w, use_rs} = 3'b111;
            end
            cpu_pkg::OP_ANDI: begin
                alu_op = cpu_pkg::ALU_AND;
                {b_imm, reg_w, use_rs, zero_ext} = 4'b1111;
            end
            cpu_pkg::OP_ORI: begin
                alu_op = cpu_pkg::ALU_OR;
                {b_imm, reg_w, use_rs, zero_ext} = 4'b1111;
            end
            cpu_pkg::OP_XORI: begin
                alu_op = cpu_pkg::ALU_XOR;
                {b_imm, reg_w, use_rs, zero_ext} = 4'b1111;
            end
            cpu_pkg::OP_SLTI: begin
                alu_op = cpu_pkg::ALU_SLT;
                {b_imm, reg_w, use_rs} = 3'b111;
            end
            // No source register
            cpu_pkg::OP_LUI: begin
                alu_op = cpu_pkg::ALU_LUI;
                {b_imm, reg_w} = 2'b11;
            end
            cpu_pkg::OP_LW: begin
                {b_imm, reg_w, mem_r, use_rs} = 4'b1111;
            end
            // Store data travels as the rt operand
            cpu_pkg::OP_SW: begin
                {b_imm, mem_w, use_rs, use_rt} = 4'b1111;
            end
            cpu_pkg::OP_BEQ: begin
                {beq, use_rs, use_rt} = 3'b111;
            end
            cpu_pkg::OP_BNE: begin
                {bne, use_rs, use_rt} = 3'b111;
            end
            default: begin
                dst_rt = 1'b1;
            end
        endcase
    end

    // Unused sources read as $0 so they never stall or forward
    assign id_rs_addr = use_rs ? if_instr[25:21] : 5'd0;
    assign id_rt_addr = use_rt ? if_instr[20:16] : 5'd0;
    assign dst_addr   = dst_rt ? if_instr[20:16] : if_instr[15:11];
    assign imm_ext    = zero_ext ? {16'h0000, if_instr[15:0]}
                                 : {{16{if_instr[15]}}, if_instr[15:0]};

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (wb_reg_w),
        .rs_addr (id_rs_addr),
        .rt_addr (id_rt_addr),
        .rd_addr (wb_rd_addr),
        .rd_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    //////////////////////////////
    // ID/EX register
    //////////////////////////////

    // Bubble on load-use stall or on a taken branch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {ex_reg_w, ex_mem_r, ex_mem_w, ex_beq, ex_bne} <= '0;
        end else if (stall || branch_taken) begin
            {ex_reg_w, ex_mem_r, ex_mem_w, ex_beq, ex_bne} <= '0;
        end else begin
            {ex_reg_w, ex_mem_r, ex_mem_w, ex_beq, ex_bne} <= {reg_w, mem_r, mem_w, beq, bne};
        end
    end

    // Payload follows every cycle
    always_ff @(posedge clk) begin
        ex_rs_addr <= id_rs_addr;
        ex_rt_addr <= id_rt_addr;
        ex_rd_addr <= dst_addr;
        ex_op_a    <= rs_data;
        ex_op_b    <= rt_data;
        ex_imm     <= imm_ext;
        ex_pc_4    <= if_pc_4;
        ex_alu_op  <= alu_op;
        ex_b_imm   <= b_imm;
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t ex_rd_addr,
    input  cpu_pkg::word_t     ex_op_a,
    input  cpu_pkg::word_t     ex_op_b,
    input  cpu_pkg::word_t     ex_imm,
    input  cpu_pkg::word_t     ex_pc_4,
    input  cpu_pkg::alu_op_t   ex_alu_op,
    input  logic               ex_b_imm,
    input  logic               ex_reg_w,
    input  logic               ex_mem_r,
    input  logic               ex_mem_w,
    input  logic               ex_beq,
    input  logic               ex_bne,
    input  cpu_pkg::fwd_sel_t  fwd_a,
    input  cpu_pkg::fwd_sel_t  fwd_b,
    input  cpu_pkg::word_t     wb_data,
    output logic               branch_taken,
    output cpu_pkg::word_t     branch_target,
    output cpu_pkg::reg_addr_t mem_rd_addr,
    output logic               mem_reg_w,
    output cpu_pkg::word_t     dmem_addr,
    output cpu_pkg::word_t     dmem_wdata,
    output logic               dmem_we,
    output logic               dmem_re,
    output cpu_pkg::word_t     mem_alu_res
);

    cpu_pkg::word_t op_a;
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t alu_b;
    cpu_pkg::word_t alu_res;
    logic           equal;

    // Forwarding source per operand
    function automatic cpu_pkg::word_t fwd_mux(
        input cpu_pkg::fwd_sel_t sel,
        input cpu_pkg::word_t    id_val,
        input cpu_pkg::word_t    mem_val,
        input cpu_pkg::word_t    wb_val
    );
        case (sel)
            cpu_pkg::FWD_MEM: return mem_val;
            cpu_pkg::FWD_WB:  return wb_val;
            default:          return id_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, ex_op_a, mem_alu_res, wb_data);
    assign op_b  = fwd_mux(fwd_b, ex_op_b, mem_alu_res, wb_data);
    assign alu_b = ex_b_imm ? ex_imm : op_b;

    //////////////////////////////
    // ALU
    //////////////////////////////

    always_comb begin
        case (ex_alu_op)
            cpu_pkg::ALU_ADD:  alu_res = op_a + alu_b;
            cpu_pkg::ALU_SUB:  alu_res = op_a - alu_b;
            cpu_pkg::ALU_AND:  alu_res = op_a & alu_b;
            cpu_pkg::ALU_OR:   alu_res = op_a | alu_b;
            cpu_pkg::ALU_XOR:  alu_res = op_a ^ alu_b;
            cpu_pkg::ALU_NOR:  alu_res = ~(op_a | alu_b);
            cpu_pkg::ALU_SLT:  alu_res = {31'd0, $signed(op_a) < $signed(alu_b)};
            cpu_pkg::ALU_SLTU: alu_res = {31'd0, op_a < alu_b};
            cpu_pkg::ALU_LUI:  alu_res = {alu_b[15:0], 16'h0000};
            default:           alu_res = op_a + alu_b;
        endcase
    end

    // Branch compare on forwarded register values
    assign equal         = (op_a == op_b);
    assign branch_taken  = (ex_beq && equal) || (ex_bne && !equal);
    assign branch_target = ex_pc_4 + {ex_imm[29:0], 2'b00};

    //////////////////////////////
    // EX/MEM register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_reg_w <= 1'b0;
            dmem_we   <= 1'b0;
            dmem_re   <= 1'b0;
        end else begin
            mem_reg_w <= ex_reg_w;
            dmem_we   <= ex_mem_w;
            dmem_re   <= ex_mem_r;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd_addr <= ex_rd_addr;
        mem_alu_res <= alu_res;
        dmem_wdata  <= op_b;
    end

    // ALU result doubles as the data address
    assign dmem_addr = mem_alu_res;

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  cpu_pkg::reg_addr_t id_rs_addr,
    input  cpu_pkg::reg_addr_t id_rt_addr,
    input  cpu_pkg::reg_addr_t ex_rs_addr,
    input  cpu_pkg::reg_addr_t ex_rt_addr,
    input  cpu_pkg::reg_addr_t ex_rd_addr,
    input  cpu_pkg::reg_addr_t mem_rd_addr,
    input  cpu_pkg::reg_addr_t wb_rd_addr,
    input  logic               ex_mem_r,
    input  logic               mem_reg_w,
    input  logic               wb_reg_w,
    output logic               stall,
    output cpu_pkg::fwd_sel_t  fwd_a,
    output cpu_pkg::fwd_sel_t  fwd_b
);

    // Load in EX feeding a source of the instruction in ID
    assign stall = ex_mem_r && (ex_rd_addr != 5'd0)
                   && ((ex_rd_addr == id_rs_addr) || (ex_rd_addr == id_rt_addr));

    //////////////////////////////
    // Forwarding selects
    //////////////////////////////

    // Younger result in MEM wins over WB
    always_comb begin
        fwd_a = cpu_pkg::FWD_NONE;
        if (mem_reg_w && (mem_rd_addr != 5'd0) && (mem_rd_addr == ex_rs_addr)) begin
            fwd_a = cpu_pkg::FWD_MEM;
        end else if (wb_reg_w && (wb_rd_addr != 5'd0) && (wb_rd_addr == ex_rs_addr)) begin
            fwd_a = cpu_pkg::FWD_WB;
        end
    end

    // Same rule for rt, which also carries store data
    always_comb begin
        fwd_b = cpu_pkg::FWD_NONE;
        if (mem_reg_w && (mem_rd_addr != 5'd0) && (mem_rd_addr == ex_rt_addr)) begin
            fwd_b = cpu_pkg::FWD_MEM;
        end else if (wb_reg_w && (wb_rd_addr != 5'd0) && (wb_rd_addr == ex_rt_addr)) begin
            fwd_b = cpu_pkg::FWD_WB;
        end
    end

endmodule

`default_nettype wire

// File: rtl/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_reg_w,
    input  logic               dmem_re,
    input  cpu_pkg::reg_addr_t mem_rd_addr,
    input  cpu_pkg::word_t     mem_alu_res,
    input  cpu_pkg::word_t     dmem_rdata,
    output logic               wb_reg_w,
    output cpu_pkg::reg_addr_t wb_rd_addr,
    output cpu_pkg::word_t     wb_data
);

    //////////////////////////////
    // MEM/WB register
    //////////////////////////////

    // Write enable cleared to a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_reg_w <= 1'b0;
        end else begin
            wb_reg_w <= mem_reg_w;
        end
    end

    // Loads take the memory word, everything else the ALU result
    always_ff @(posedge clk) begin
        wb_rd_addr <= mem_rd_addr;
        wb_data    <= dmem_re ? dmem_rdata : mem_alu_res;
    end

endmodule

`default_nettype wire

// File: rtl/pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline (
    input  logic           clk,
    input  logic           rst_n,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_data,
    output cpu_pkg::word_t dmem_addr,
    output cpu_pkg::word_t dmem_wdata,
    output logic           dmem_we,
    output logic           dmem_re,
    input  cpu_pkg::word_t dmem_rdata
);

    // IF/ID outputs
    cpu_pkg::word_t     if_pc_4;
    cpu_pkg::word_t     if_instr;

    // Redirects
    logic               jump_taken;
    cpu_pkg::word_t     jump_target;
    logic               branch_taken;
    cpu_pkg::word_t     branch_target;

    // Hazard controls
    logic               stall;
    cpu_pkg::fwd_sel_t  fwd_a;
    cpu_pkg::fwd_sel_t  fwd_b;

    // ID/EX outputs
    cpu_pkg::reg_addr_t id_rs_addr;
    cpu_pkg::reg_addr_t id_rt_addr;
    cpu_pkg::reg_addr_t ex_rs_addr;
    cpu_pkg::reg_addr_t ex_rt_addr;
    cpu_pkg::reg_addr_t ex_rd_addr;
    cpu_pkg::word_t     ex_op_a;
    cpu_pkg::word_t     ex_op_b;
    cpu_pkg::word_t     ex_imm;
    cpu_pkg::word_t     ex_pc_4;
    cpu_pkg::alu_op_t   ex_alu_op;
    logic               ex_b_imm;
    logic               ex_reg_w;
    logic               ex_mem_r;
    logic               ex_mem_w;
    logic               ex_beq;
    logic               ex_bne;

    // EX/MEM outputs
    cpu_pkg::reg_addr_t mem_rd_addr;
    logic               mem_reg_w;
    cpu_pkg::word_t     mem_alu_res;

    // MEM/WB outputs
    logic               wb_reg_w;
    cpu_pkg::reg_addr_t wb_rd_addr;
    cpu_pkg::word_t     wb_data;

    //////////////////////////////
    // Stages
    //////////////////////////////

    fetch_stage u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .jump_taken    (jump_taken),
        .branch_taken  (branch_taken),
        .jump_target   (jump_target),
        .branch_target (branch_target),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .if_pc_4       (if_pc_4),
        .if_instr      (if_instr)
    );

    decode_stage u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .branch_taken (branch_taken),
        .if_pc_4      (if_pc_4),
        .if_instr     (if_instr),
        .wb_reg_w     (wb_reg_w),
        .wb_rd_addr   (wb_rd_addr),
        .wb_data      (wb_data),
        .jump_taken   (jump_taken),
        .jump_target  (jump_target),
        .id_rs_addr   (id_rs_addr),
        .id_rt_addr   (id_rt_addr),
        .ex_rs_addr   (ex_rs_addr),
        .ex_rt_addr   (ex_rt_addr),
        .ex_rd_addr   (ex_rd_addr),
        .ex_op_a      (ex_op_a),
        .ex_op_b      (ex_op_b),
        .ex_imm       (ex_imm),
        .ex_pc_4      (ex_pc_4),
        .ex_alu_op    (ex_alu_op),
        .ex_b_imm     (ex_b_imm),
        .ex_reg_w     (ex_reg_w),
        .ex_mem_r     (ex_mem_r),
        .ex_mem_w     (ex_mem_w),
        .ex_beq       (ex_beq),
        .ex_bne       (ex_bne)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_rd_addr    (ex_rd_addr),
        .ex_op_a       (ex_op_a),
        .ex_op_b       (ex_op_b),
        .ex_imm        (ex_imm),
        .ex_pc_4       (ex_pc_4),
        .ex_alu_op     (ex_alu_op),
        .ex_b_imm      (ex_b_imm),
        .ex_reg_w      (ex_reg_w),
        .ex_mem_r      (ex_mem_r),
        .ex_mem_w      (ex_mem_w),
        .ex_beq        (ex_beq),
        .ex_bne        (ex_bne),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .wb_data       (wb_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .mem_rd_addr   (mem_rd_addr),
        .mem_reg_w     (mem_reg_w),
        .dmem_addr     (dmem_addr),
        .dmem_wdata    (dmem_wdata),
        .dmem_we       (dmem_we),
        .dmem_re       (dmem_re),
        .mem_alu_res   (mem_alu_res)
    );

    writeback_stage u_writeback (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_reg_w   (mem_reg_w),
        .dmem_re     (dmem_re),
        .mem_rd_addr (mem_rd_addr),
        .mem_alu_res (mem_alu_res),
        .dmem_rdata  (dmem_rdata),
        .wb_reg_w    (wb_reg_w),
        .wb_rd_addr  (wb_rd_addr),
        .wb_data     (wb_data)
    );

    // Stall and forwarding control
    hazard_unit u_hazard (
        .id_rs_addr  (id_rs_addr),
        .id_rt_addr  (id_rt_addr),
        .ex_rs_addr  (ex_rs_addr),
        .ex_rt_addr  (ex_rt_addr),
        .ex_rd_addr  (ex_rd_addr),
        .mem_rd_addr (mem_rd_addr),
        .wb_rd_addr  (wb_rd_addr),
        .ex_mem_r    (ex_mem_r),
        .mem_reg_w   (mem_reg_w),
        .wb_reg_w    (wb_reg_w),
        .stall       (stall),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b)
    );

endmodule

`default_nettype wire

// File: verif/tb_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline;

    // Trace layout
    localparam int PROG_WORDS   = 64;
    localparam int MAX_STORES   = 32;
    localparam int COUNT_IDX    = PROG_WORDS;
    localparam int PAIR_BASE    = PROG_WORDS + 1;
    localparam int TRACE_WORDS  = PROG_WORDS + 1 + 2 * MAX_STORES;
    localparam int RAM_WORDS    = 256;

    // Run length
    localparam int RESET_CYCLES   = 16;
    localparam int DRAIN_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 8 * PROG_WORDS;

    logic           clk;
    logic           rst_n;
    cpu_pkg::word_t imem_addr;
    cpu_pkg::word_t imem_data;
    cpu_pkg::word_t dmem_addr;
    cpu_pkg::word_t dmem_wdata;
    logic           dmem_we;
    logic           dmem_re;
    cpu_pkg::word_t dmem_rdata;

    // Program words, store count, then address/data pairs
    cpu_pkg::word_t trace [TRACE_WORDS] = '{default: '0};
    // Data RAM starts cleared
    cpu_pkg::word_t ram [RAM_WORDS] = '{default: '0};

    int n_stores    = 0;
    int stores_seen = 0;
    int cycle_count = 0;

    pipeline DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    //////////////////////////////
    // Clock and memories
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ROM is the program part of the trace, word addressed
    assign imem_data  = trace[imem_addr[7:2]];
    assign dmem_rdata = ram[dmem_addr[9:2]];

    // Store lands at the rising edge
    always @(posedge clk) begin
        if (dmem_we === 1'b1) begin
            ram[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_word(
        input string          name,
        input cpu_pkg::word_t got,
        input cpu_pkg::word_t expected
    );
        if (got !== expected) begin
            $display("error at %0t ns: %s got %h, expected %h", $time, name, got, expected);
            $display("Simulation failed");
            $fatal(1, "store mismatch");
        end
    endtask

    function automatic cpu_pkg::word_t expected_addr(input int idx);
        return trace[PAIR_BASE + 2 * idx];
    endfunction

    function automatic cpu_pkg::word_t expected_data(input int idx);
        return trace[PAIR_BASE + 2 * idx + 1];
    endfunction

    // Sampled mid-cycle, where EX/MEM outputs are settled
    always @(negedge clk) begin
        if (!rst_n) begin
            // No memory strobe while in reset
            if (dmem_we !== 1'b0 || dmem_re !== 1'b0) begin
                $display("A data memory strobe was active while reset was held");
                $display("Simulation failed");
                $fatal(1, "strobe during reset");
            end
        end else if (dmem_we === 1'b1) begin
            if (stores_seen >= n_stores) begin
                $display("An extra store to address %h appeared after all %0d expected stores",
                         dmem_addr, n_stores);
                $display("Simulation failed");
                $fatal(1, "extra store");
            end
            check_word("store address", dmem_addr, expected_addr(stores_seen));
            check_word("store data", dmem_wdata, expected_data(stores_seen));
            stores_seen = stores_seen + 1;
        end else if (dmem_we !== 1'b0) begin
            $display("The store strobe was neither high nor low after reset");
            $display("Simulation failed");
            $fatal(1, "unknown strobe");
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timed out after %0d cycles with only %0d of %0d expected stores seen",
                     cycle_count, stores_seen, n_stores);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst_n = 1'b0;
        $readmemh("verif/pipeline_trace.hex", trace);
        n_stores = int'(trace[COUNT_IDX]);
        if (n_stores < 1 || n_stores > MAX_STORES) begin
            $display("The trace file holds an unusable store count of %0d", n_stores);
            $display("Simulation failed");
            $fatal(1, "bad trace");
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        wait (stores_seen == n_stores);
        // Window for a stray store from a flushed path
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/pipeline_trace.hex
// Words 0-63: program, one instruction word per line
// Word 64: store count N, then N lines of store address and store data
3C011234 // 00 lui   $1, 0x1234
34215678 // 04 ori   $1, $1, 0x5678     -> 12345678
2002FFFD // 08 addi  $2, $0, -3         -> fffffffd
00221820 // 0c add   $3, $1, $2         -> 12345675
AC030000 // 10 sw    $3, 0($0)
0040202A // 14 slt   $4, $2, $0         -> 1
0040282B // 18 sltu  $5, $2, $0         -> 0
00853027 // 1c nor   $6, $4, $5         -> fffffffe
00C13822 // 20 sub   $7, $6, $1         -> edcba986
AC070004 // 24 sw    $7, 4($0)
38E8FFFF // 28 xori  $8, $7, 0xffff     -> edcb5679
31090FF0 // 2c andi  $9, $8, 0x0ff0     -> 00000670
AC090008 // 30 sw    $9, 8($0)
8C0A0004 // 34 lw    $10, 4($0)         -> edcba986
254B0001 // 38 addiu $11, $10, 1        -> edcba987
AC0B000C // 3c sw    $11, 12($0)
284CFFFE // 40 slti  $12, $2, -2        -> 1
11800001 // 44 beq   $12, $0, +1        not taken
AC0C0010 // 48 sw    $12, 16($0)
15800002 // 4c bne   $12, $0, +2        taken to 58
AC010014 // 50 sw    $1, 20($0)         flushed
AC020018 // 54 sw    $2, 24($0)         flushed
10630001 // 58 beq   $3, $3, +1         taken to 60
AC03001C // 5c sw    $3, 28($0)         flushed
0800001C // 60 j     0x70
AC040020 // 64 sw    $4, 32($0)         flushed
00000000 // 68
00000000 // 6c
016C6825 // 70 or    $13, $11, $12      -> edcba987
01A17026 // 74 xor   $14, $13, $1       -> ffffffff
01C47823 // 78 subu  $15, $14, $4       -> fffffffe
01E88024 // 7c and   $16, $15, $8       -> edcb5678
02058821 // 80 addu  $17, $16, $5       -> edcb5678
AC110014 // 84 sw    $17, 20($0)
AC0F0018 // 88 sw    $15, 24($0)
8C120000 // 8c lw    $18, 0($0)         -> 12345675
AC12001C // 90 sw    $18, 28($0)
08000025 // 94 j     0x94               self-loop
@40
00000008
00000000 12345675
00000004 EDCBA986
00000008 00000670
0000000C EDCBA987
00000010 00000001
00000014 EDCB5678
00000018 FFFFFFFE
0000001C 12345675

// File: sources.f
rtl/cpu_pkg.sv
rtl/reg_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/hazard_unit.sv
rtl/writeback_stage.sv
rtl/pipeline.sv
verif/tb_pipeline.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipeline
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
